/* all.f */
+incdir+include
hdl/icache_pkg.sv
hdl/icache_ram.sv
hdl/icache_lookup.sv
hdl/icache_fill.sv
hdl/icache_top.sv
tests/icache_tb.sv

/* run.sh */
#!/bin/sh
# Build the cache testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f all.f --top-module icache_tb -o icache_tb_sim \
    && ./obj_dir/icache_tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "All tests passed" sim.log || { echo "Simulation failed, see sim.log"; exit 1; }

/* include/icache_tb_util.svh */
/*
 * Testbench helpers for the instruction cache
 * Pseudo random numbers, result checks and fatal error reporting
 */
`ifndef ICACHE_TB_UTIL_SVH
`define ICACHE_TB_UTIL_SVH

// Number of comparisons made so far
int check_count = 0;

// Next state of a 32-bit linear congruential generator
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// Value in 0 .. n-1 taken from the better upper bits of the state
function automatic int unsigned lcg_range(input logic [31:0] state, input int unsigned n);
    return (state >> 16) % n;
endfunction

// Ends the run with the reason of the failure
task automatic fatal_error(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "simulation stopped after %0d checks", check_count);
endtask

// Compares one observed value against the expected one
task automatic check(
    input string       what,
    input logic [31:0] got,
    input logic [31:0] expected
);
    check_count++;
    if (got !== expected) begin
        fatal_error($sformatf("FAIL at %0t: %s, got %h, expected %h",
                              $time, what, got, expected));
    end
endtask

`endif

/* tests/icache_tb.sv */
/*
 * Testbench for the 2-way instruction cache
 * Random-delay memory, reference directory model, directed and random fetches
 */
`timescale 1ns/1ps

module icache_tb;

    `include "icache_tb_util.svh"

    localparam int mem_words = 1 << 19;
    localparam int random_accesses = 500;
    localparam int directed_accesses = 40;
    // Eight words at up to five cycles each plus the handshake around the fill
    localparam int worst_access_cycles = 50;
    localparam int timeout_cycles = (random_accesses + directed_accesses)
                                    * worst_access_cycles + 100;

    logic clk;
    logic reset;
    icache_pkg::addr_t c_addr;
    logic              c_access;
    icache_pkg::word_t c_data;
    logic              c_ack;
    icache_pkg::addr_t m_addr;
    logic              m_access;
    icache_pkg::word_t m_data;
    logic              m_ack;
    logic              inval_valid;
    icache_pkg::addr_t inval_addr;
    logic              coh_wr_valid;
    icache_pkg::addr_t coh_wr_addr;

    icache_pkg::word_t mem [mem_words];
    logic [31:0] stim_rng;
    int cycle_count;
    icache_pkg::addr_t cur_addr;
    int fill_words;

    // Reference directory
    icache_pkg::tag_t model_tag [2][icache_pkg::sets];
    logic model_valid [2][icache_pkg::sets];
    logic model_lru [icache_pkg::sets];

    icache_pkg::tag_t tag_pool [4] = '{8'h21, 8'h5a, 8'h93, 8'hc4};
    icache_pkg::index_t index_pool [4] = '{8'h10, 8'h11, 8'h80, 8'hff};

    icache_top icache_top_i (
        .clk          (clk),
        .reset        (reset),
        .c_addr       (c_addr),
        .c_access     (c_access),
        .c_data       (c_data),
        .c_ack        (c_ack),
        .m_addr       (m_addr),
        .m_access     (m_access),
        .m_data       (m_data),
        .m_ack        (m_ack),
        .inval_valid  (inval_valid),
        .inval_addr   (inval_addr),
        .coh_wr_valid (coh_wr_valid),
        .coh_wr_addr  (coh_wr_addr)
    );

    always #10 clk = ~clk;

    function automatic icache_pkg::addr_t make_addr(input icache_pkg::tag_t t,
                                                   input icache_pkg::index_t i,
                                                   input icache_pkg::offset_t o);
        return {t, i, o};
    endfunction

    // Hit on a matching valid way, otherwise refill the LRU way
    task automatic model_access(input icache_pkg::addr_t addr, output logic hit);
        icache_pkg::index_t idx;
        logic way;
        idx = addr[11:4];
        hit = 1'b0;
        way = model_lru[idx];
        for (int w = 0; w < 2; w++) begin
            if (model_valid[w][idx] && model_tag[w][idx] == addr[19:12]) begin
                hit = 1'b1;
                way = 1'(w);
            end
        end
        if (!hit) begin
            model_tag[way][idx] = addr[19:12];
            model_valid[way][idx] = 1'b1;
        end
        model_lru[idx] = !way;
    endtask

    // want is 1 for an intended hit, 0 for a miss and -1 when the model decides
    task automatic fetch(input icache_pkg::addr_t addr, input int want);
        logic exp_hit;
        logic saw_mem;
        int waited;
        icache_pkg::word_t exp_data;
        exp_data = mem[addr];
        model_access(addr, exp_hit);
        if (want >= 0) begin
            check("model hit for directed case", 32'(exp_hit), 32'(want));
        end
        cur_addr = addr;
        fill_words = 0;
        saw_mem = 1'b0;
        waited = 0;
        c_addr = addr;
        c_access = 1'b1;
        do begin
            @(negedge clk);
            waited++;
            if (m_access) begin
                saw_mem = 1'b1;
            end
        end while (!c_ack);
        check("fetched word", 32'(c_data), 32'(exp_data));
        check("memory request seen", 32'(saw_mem), 32'(!exp_hit));
        if (exp_hit) begin
            check("hit latency", 32'(waited), 32'd2);
        end else begin
            check("words fetched for the line", 32'(fill_words), 32'd8);
        end
        @(posedge clk);
        #2;
        c_access = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic invalidate_set(input icache_pkg::addr_t addr);
        model_valid[0][addr[11:4]] = 1'b0;
        model_valid[1][addr[11:4]] = 1'b0;
        inval_addr = addr;
        inval_valid = 1'b1;
        @(posedge clk);
        #2;
        inval_valid = 1'b0;
    endtask

    // Data side store, memory takes the new word at once
    task automatic coherence_write(input icache_pkg::addr_t addr);
        stim_rng = lcg_next(stim_rng);
        mem[addr] = stim_rng[31:16];
        for (int w = 0; w < 2; w++) begin
            if (model_valid[w][addr[11:4]] && model_tag[w][addr[11:4]] == addr[19:12]) begin
                model_valid[w][addr[11:4]] = 1'b0;
            end
        end
        coh_wr_addr = addr;
        coh_wr_valid = 1'b1;
        @(posedge clk);
        #2;
        coh_wr_valid = 1'b0;
    endtask

    task automatic pick_addr(output icache_pkg::addr_t a);
        icache_pkg::tag_t t;
        icache_pkg::index_t i;
        stim_rng = lcg_next(stim_rng);
        t = tag_pool[2'(lcg_range(stim_rng, 4))];
        stim_rng = lcg_next(stim_rng);
        i = index_pool[2'(lcg_range(stim_rng, 4))];
        stim_rng = lcg_next(stim_rng);
        a = make_addr(t, i, icache_pkg::offset_t'(lcg_range(stim_rng, 8)));
    endtask

    // Memory answers each word after 0 to 3 idle cycles
    initial begin
        int wait_left;
        logic pending;
        logic [31:0] delay_rng;
        m_ack = 1'b0;
        m_data = '0;
        pending = 1'b0;
        wait_left = 0;
        delay_rng = 32'h676b;
        forever begin
            @(posedge clk);
            #2;
            if (m_ack) begin
                m_ack = 1'b0;
            end else if (m_access) begin
                if (!pending) begin
                    delay_rng = lcg_next(delay_rng);
                    wait_left = lcg_range(delay_rng, 4);
                    pending = 1'b1;
                end
                if (wait_left == 0) begin
                    check("memory word address", 32'(m_addr),
                        32'({cur_addr[19:4], icache_pkg::offset_t'(fill_words)}));
                    m_data = mem[m_addr];
                    m_ack = 1'b1;
                    pending = 1'b0;
                    fill_words++;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        fatal_error($sformatf("Timeout: the cache gave no answer within %0d clock cycles",
                              cycle_count));
    end

    initial begin
        icache_pkg::addr_t a;
        clk = 1'b0;
        reset = 1'b1;
        c_addr = '0;
        c_access = 1'b0;
        inval_valid = 1'b0;
        inval_addr = '0;
        coh_wr_valid = 1'b0;
        coh_wr_addr = '0;
        stim_rng = 32'h676b;
        for (int i = 0; i < mem_words; i++) begin
            stim_rng = lcg_next(stim_rng);
            mem[i] = stim_rng[31:16];
        end
        for (int s = 0; s < icache_pkg::sets; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_lru[s] = 1'b0;
        end
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        @(posedge clk);
        #2;

        // Both handshakes are quiet out of reset
        check("c_ack after reset", 32'(c_ack), 32'd0);
        check("m_access after reset", 32'(m_access), 32'd0);

        // Miss in the middle of a line, then every word of it hits
        fetch(make_addr(8'h12, 8'h05, 3'd5), 0);
        for (int o = 0; o < 8; o++) begin
            fetch(make_addr(8'h12, 8'h05, 3'(o)), 1);
        end

        // A, B, A, C on one set: C evicts B
        fetch(make_addr(8'h01, 8'h20, 3'd0), 0);
        fetch(make_addr(8'h02, 8'h20, 3'd1), 0);
        fetch(make_addr(8'h01, 8'h20, 3'd2), 1);
        fetch(make_addr(8'h03, 8'h20, 3'd3), 0);
        fetch(make_addr(8'h01, 8'h20, 3'd4), 1);
        fetch(make_addr(8'h02, 8'h20, 3'd5), 0);

        // Index invalidation leaves the neighbour set alone
        fetch(make_addr(8'h04, 8'h30, 3'd0), 0);
        fetch(make_addr(8'h05, 8'h30, 3'd1), 0);
        fetch(make_addr(8'h04, 8'h31, 3'd2), 0);
        invalidate_set(make_addr(8'h00, 8'h30, 3'd0));
        fetch(make_addr(8'h04, 8'h30, 3'd3), 0);
        fetch(make_addr(8'h05, 8'h30, 3'd4), 0);
        fetch(make_addr(8'h04, 8'h31, 3'd5), 1);

        // Store with a foreign tag, then one that hits way of tag 06
        fetch(make_addr(8'h06, 8'h40, 3'd0), 0);
        fetch(make_addr(8'h07, 8'h40, 3'd1), 0);
        coherence_write(make_addr(8'h09, 8'h40, 3'd2));
        fetch(make_addr(8'h06, 8'h40, 3'd3), 1);
        fetch(make_addr(8'h07, 8'h40, 3'd4), 1);
        coherence_write(make_addr(8'h06, 8'h40, 3'd2));
        fetch(make_addr(8'h07, 8'h40, 3'd6), 1);
        fetch(make_addr(8'h06, 8'h40, 3'd2), 0);

        for (int n = 0; n < random_accesses; n++) begin
            stim_rng = lcg_next(stim_rng);
            case (lcg_range(stim_rng, 16))
                0: begin
                    pick_addr(a);
                    invalidate_set(a);
                end
                1: begin
                    pick_addr(a);
                    coherence_write(a);
                end
                default: ;
            endcase
            pick_addr(a);
            fetch(a, -1);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

/* hdl/icache_top.sv */
/*
 * 2-way set-associative instruction cache, top level
 * Joins the directory, the fill sequencer and the two way line RAMs
 */
`timescale 1ns/1ps

module icache_top (
    input  logic              clk,
    input  logic              reset,
    input  icache_pkg::addr_t c_addr,
    input  logic              c_access,
    output icache_pkg::word_t c_data,
    output logic              c_ack,
    output icache_pkg::addr_t m_addr,
    output logic              m_access,
    input  icache_pkg::word_t m_data,
    input  logic              m_ack,
    input  logic              inval_valid,
    input  icache_pkg::addr_t inval_addr,
    input  logic              coh_wr_valid,
    input  icache_pkg::addr_t coh_wr_addr
);

    logic [icache_pkg::ram_addr_bits-1:0] rd_addr;
    icache_pkg::word_t     rd_data0;
    icache_pkg::word_t     rd_data1;
    logic                  fill_start;
    icache_pkg::fill_req_t fill_req;
    icache_pkg::fill_wr_t  fill_wr;
    logic                  fill_done;

    icache_lookup lookup_i (
        .clk          (clk),
        .reset        (reset),
        .c_addr       (c_addr),
        .c_access     (c_access),
        .c_ack        (c_ack),
        .c_data       (c_data),
        .rd_data0     (rd_data0),
        .rd_data1     (rd_data1),
        .rd_addr      (rd_addr),
        .fill_start   (fill_start),
        .fill_req     (fill_req),
        .fill_wr      (fill_wr),
        .fill_done    (fill_done),
        .inval_valid  (inval_valid),
        .inval_addr   (inval_addr),
        .coh_wr_valid (coh_wr_valid),
        .coh_wr_addr  (coh_wr_addr)
    );

    icache_fill fill_i (
        .clk        (clk),
        .reset      (reset),
        .fill_start (fill_start),
        .fill_req   (fill_req),
        .fill_wr    (fill_wr),
        .fill_done  (fill_done),
        .m_addr     (m_addr),
        .m_access   (m_access),
        .m_data     (m_data),
        .m_ack      (m_ack)
    );

    // One line RAM per way, the fill way picks the write enable
    icache_ram #(
        .words (icache_pkg::sets * icache_pkg::line_words),
        .width ($bits(icache_pkg::word_t))
    ) ram0_i (
        .clk     (clk),
        .wr_en   (fill_wr.valid && !fill_wr.way),
        .wr_addr ({fill_wr.index, fill_wr.offset}),
        .wr_data (fill_wr.data),
        .rd_addr (rd_addr),
        .rd_data (rd_data0)
    );

    icache_ram #(
        .words (icache_pkg::sets * icache_pkg::line_words),
        .width ($bits(icache_pkg::word_t))
    ) ram1_i (
        .clk     (clk),
        .wr_en   (fill_wr.valid && fill_wr.way),
        .wr_addr ({fill_wr.index, fill_wr.offset}),
        .wr_data (fill_wr.data),
        .rd_addr (rd_addr),
        .rd_data (rd_data1)
    );

endmodule

/* hdl/icache_fill.sv */
/*
 * Line fill sequencer: fetches the eight words of a missed line
 * from memory in order and streams them into the line RAMs
 */
`timescale 1ns/1ps

module icache_fill (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fill_start,
    input  icache_pkg::fill_req_t fill_req,
    output icache_pkg::fill_wr_t  fill_wr,
    output logic                  fill_done,
    output icache_pkg::addr_t     m_addr,
    output logic                  m_access,
    input  icache_pkg::word_t     m_data,
    input  logic                  m_ack
);

    icache_pkg::fill_state_t state_q;
    icache_pkg::fill_req_t   req_q;
    icache_pkg::offset_t     offset_q;

    logic word_ack;
    logic last_word;

    assign word_ack = (state_q == icache_pkg::fill_fetch) && m_ack;
    assign last_word = (offset_q == icache_pkg::offset_t'(icache_pkg::line_words - 1));

    // Memory request stays up for the whole line
    assign m_access = (state_q == icache_pkg::fill_fetch);
    assign m_addr = {req_q.tag, req_q.index, offset_q};

    assign fill_done = (state_q == icache_pkg::fill_finish);

    // Each acknowledged word goes straight to the RAM of the victim way
    always_comb begin
        fill_wr.valid = word_ack;
        fill_wr.way = req_q.way;
        fill_wr.index = req_q.index;
        fill_wr.offset = offset_q;
        fill_wr.data = m_data;
        fill_wr.last = last_word;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= icache_pkg::fill_idle;
            offset_q <= '0;
        end else begin
            case (state_q)
                icache_pkg::fill_idle: begin
                    if (fill_start) begin
                        state_q <= icache_pkg::fill_fetch;
                        offset_q <= '0;
                    end
                end
                icache_pkg::fill_fetch: begin
                    // Nothing moves until memory answers
                    if (m_ack) begin
                        offset_q <= offset_q + 1'b1;
                        if (last_word) begin
                            state_q <= icache_pkg::fill_finish;
                        end
                    end
                end
                icache_pkg::fill_finish: begin
                    state_q <= icache_pkg::fill_idle;
                end
                default: state_q <= icache_pkg::fill_idle;
            endcase
        end
    end

    // Request of the current miss
    always_ff @(posedge clk) begin
        if (state_q == icache_pkg::fill_idle && fill_start) begin
            req_q <= fill_req;
        end
    end

endmodule

/* hdl/icache_lookup.sv */
/*
 * Instruction cache directory with tag, valid and LRU state per set
 * Decides hit or miss, acknowledges the CPU and requests line fills
 */
`timescale 1ns/1ps

module icache_lookup (
    input  logic                                    clk,
    input  logic                                    reset,
    input  icache_pkg::addr_t                       c_addr,
    input  logic                                    c_access,
    output logic                                    c_ack,
    output icache_pkg::word_t                       c_data,
    input  icache_pkg::word_t                       rd_data0,
    input  icache_pkg::word_t                       rd_data1,
    output logic [icache_pkg::ram_addr_bits-1:0]    rd_addr,
    output logic                                    fill_start,
    output icache_pkg::fill_req_t                   fill_req,
    input  icache_pkg::fill_wr_t                    fill_wr,
    input  logic                                    fill_done,
    input  logic                                    inval_valid,
    input  icache_pkg::addr_t                       inval_addr,
    input  logic                                    coh_wr_valid,
    input  icache_pkg::addr_t                       coh_wr_addr
);

    typedef enum logic [1:0] {
        lk_idle,
        lk_compare,
        lk_fill
    } lookup_state_t;

    lookup_state_t state_q;
    icache_pkg::addr_t req_addr;

    icache_pkg::tag_t tags [2][icache_pkg::sets];
    logic [1:0] valid [icache_pkg::sets];
    logic lru [icache_pkg::sets];

    icache_pkg::tag_t   req_tag;
    icache_pkg::index_t req_index;
    icache_pkg::index_t inval_index;
    icache_pkg::index_t coh_index;
    icache_pkg::tag_t   coh_tag;

    logic [1:0] match;
    logic [1:0] coh_match;
    logic hit;
    logic hit_way;

    assign req_tag = req_addr[19:12];
    assign req_index = req_addr[11:4];
    assign inval_index = inval_addr[11:4];
    assign coh_index = coh_wr_addr[11:4];
    assign coh_tag = coh_wr_addr[19:12];

    // Line RAMs read the CPU address every cycle, data is ready one cycle later
    assign rd_addr = c_addr[11:1];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            match[w] = valid[req_index][w] && (tags[w][req_index] == req_tag);
            coh_match[w] = coh_wr_valid && valid[coh_index][w]
                           && (tags[w][coh_index] == coh_tag);
        end
    end

    assign hit = |match;
    assign hit_way = match[1];

    // The compare state also serves as the re-read after a fill
    assign c_ack = (state_q == lk_compare) && hit;
    assign c_data = hit_way ? rd_data1 : rd_data0;

    assign fill_start = (state_q == lk_compare) && !hit;

    // Victim is the way the LRU bit points at
    always_comb begin
        fill_req.index = req_index;
        fill_req.tag = req_tag;
        fill_req.way = lru[req_index];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= lk_idle;
        end else begin
            case (state_q)
                lk_idle: begin
                    if (c_access) begin
                        state_q <= lk_compare;
                    end
                end
                lk_compare: begin
                    // CPU drops c_access after the ack, so idle is safe here
                    state_q <= hit ? lk_idle : lk_fill;
                end
                lk_fill: begin
                    if (fill_done) begin
                        state_q <= lk_compare;
                    end
                end
                default: state_q <= lk_idle;
            endcase
        end
    end

    // Address of the access, stable until the ack
    always_ff @(posedge clk) begin
        if (state_q == lk_idle && c_access) begin
            req_addr <= c_addr;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < icache_pkg::sets; s++) begin
                tags[0][s] <= '0;
                tags[1][s] <= '0;
                valid[s] <= 2'b00;
                lru[s] <= 1'b0;
            end
        end else begin
            // Index invalidation drops both ways of the set
            if (inval_valid) begin
                valid[inval_index] <= 2'b00;
            end
            // Data-side write only drops the way holding that line
            for (int w = 0; w < 2; w++) begin
                if (coh_match[w]) begin
                    valid[coh_index][w] <= 1'b0;
                end
            end
            if (c_ack) begin
                lru[req_index] <= ~hit_way;
            end
            // Line becomes valid once its eighth word is written
            if (fill_wr.valid && fill_wr.last) begin
                tags[fill_wr.way][fill_wr.index] <= req_tag;
                valid[fill_wr.index][fill_wr.way] <= 1'b1;
                lru[fill_wr.index] <= ~fill_wr.way;
            end
        end
    end

endmodule

/* hdl/icache_ram.sv */
/*
 * Simple dual-port RAM with registered read, one read and one write port
 * Holds the line data of one cache way
 */
`timescale 1ns/1ps

module icache_ram #(
    parameter int words = 2048,
    parameter int width = 16
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(words)-1:0] wr_addr,
    input  logic [width-1:0]         wr_data,
    input  logic [$clog2(words)-1:0] rd_addr,
    output logic [width-1:0]         rd_data
);

    logic [width-1:0] mem [words];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // A read of the address being written returns the old word
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* hdl/icache_pkg.sv */
/*
 * Instruction cache package: geometry, address field types,
 * fill machine states and the structs passed between the cache blocks
 */
package icache_pkg;

    // Cache geometry
    localparam int sets = 256;
    localparam int line_words = 8;
    localparam int index_bits = 8;
    localparam int tag_bits = 8;
    localparam int offset_bits = 3;

    // Word address of one line RAM, index above offset
    localparam int ram_addr_bits = index_bits + offset_bits;

    // CPU word address, bit 0 is the byte lane and is never carried
    typedef logic [19:1] addr_t;

    // Instruction word
    typedef logic [15:0] word_t;

    typedef logic [index_bits-1:0] index_t;
    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [offset_bits-1:0] offset_t;

    // Line fill sequencer states
    typedef enum logic [1:0] {
        fill_idle,
        fill_fetch,
        fill_finish
    } fill_state_t;

    // Miss request from the directory to the fill sequencer
    typedef struct packed {
        index_t index;
        tag_t   tag;
        logic   way;
    } fill_req_t;

    // One word returned by memory on its way into the line RAMs
    typedef struct packed {
        logic    valid;
        logic    way;
        index_t  index;
        offset_t offset;
        word_t   data;
        logic    last;
    } fill_wr_t;

endpackage
